// ==== hazardPkg.sv ====
`default_nettype none

package hazardPkg;

	// General register index, register 0 reads as zero
	typedef logic [4:0] regIdx_t;

	// ALU operand forwarding select
	typedef logic [1:0] fwdSel_t;

	// HI/LO write select, 2'b10 writes both
	typedef logic [1:0] hiloSel_t;

	// HI/LO forwarding select
	typedef logic [2:0] hiloFwd_t;

	localparam fwdSel_t FwdNone  = 2'd0;	// Register file value
	localparam fwdSel_t FwdExMem = 2'd1;	// Result from EX/MEM
	localparam fwdSel_t FwdMemWb = 2'd2;	// Result from MEM/WB

	localparam hiloFwd_t HiloNone  = 3'd0;	// HI/LO register value
	localparam hiloFwd_t HiloExHi  = 3'd1;
	localparam hiloFwd_t HiloExLo  = 3'd2;
	localparam hiloFwd_t HiloExOne = 3'd3;	// Single HI or LO write in EX/MEM
	localparam hiloFwd_t HiloWbHi  = 3'd4;
	localparam hiloFwd_t HiloWbLo  = 3'd5;
	localparam hiloFwd_t HiloWbOne = 3'd6;	// Single HI or LO write in MEM/WB

endpackage

`default_nettype wire

// ==== ifIdStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module ifIdStage (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       stall,
	input  wire  hazardPkg::regIdx_t  inRs,
	input  wire  hazardPkg::regIdx_t  inRt,
	input  wire  hazardPkg::regIdx_t  inDest,
	input  wire                       inRfWr,
	input  wire                       inDmRd,
	input  wire                       inCp0Rd,
	input  wire                       inBjOp,
	input  wire                       inRhlWr,
	input  wire                       inRhlSelRd,
	input  wire  hazardPkg::hiloSel_t inRhlSelWr,
	output hazardPkg::regIdx_t        idRs,
	output hazardPkg::regIdx_t        idRt,
	output hazardPkg::regIdx_t        idDest,
	output logic                      idRfWr,
	output logic                      idDmRd,
	output logic                      idCp0Rd,
	output logic                      idBjOp,
	output logic                      idRhlWr,
	output logic                      idRhlSelRd,
	output hazardPkg::hiloSel_t       idRhlSelWr
);

	always_ff @(posedge clk) begin
		if (rst) begin
			idRfWr  <= 1'b0;
			idDmRd  <= 1'b0;
			idCp0Rd <= 1'b0;
			idBjOp  <= 1'b0;
			idRhlWr <= 1'b0;
		end else if (!stall) begin
			idRfWr  <= inRfWr;
			idDmRd  <= inDmRd;
			idCp0Rd <= inCp0Rd;
			idBjOp  <= inBjOp;	// Branch resolved in decode
			idRhlWr <= inRhlWr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin	// Held descriptor re-enters decode
			idRs       <= inRs;
			idRt       <= inRt;
			idDest     <= inDest;
			idRhlSelRd <= inRhlSelRd;
			idRhlSelWr <= inRhlSelWr;
		end
	end

endmodule

`default_nettype wire

// ==== idExStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module idExStage (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       stall,
	input  wire  hazardPkg::regIdx_t  idRs,
	input  wire  hazardPkg::regIdx_t  idRt,
	input  wire  hazardPkg::regIdx_t  idDest,
	input  wire                       idRfWr,
	input  wire                       idDmRd,
	input  wire                       idCp0Rd,
	input  wire                       idRhlWr,
	input  wire                       idRhlSelRd,
	input  wire  hazardPkg::hiloSel_t idRhlSelWr,
	output hazardPkg::regIdx_t        exRs,
	output hazardPkg::regIdx_t        exRt,
	output hazardPkg::regIdx_t        exDest,
	output logic                      exRfWr,
	output logic                      exDmRd,
	output logic                      exCp0Rd,
	output logic                      exRhlWr,
	output logic                      exRhlSelRd,
	output hazardPkg::hiloSel_t       exRhlSelWr
);

	always_ff @(posedge clk) begin
		if (rst || stall) begin	// Reset or bubble
			exRfWr  <= 1'b0;
			exDmRd  <= 1'b0;
			exCp0Rd <= 1'b0;
			exRhlWr <= 1'b0;
		end else begin
			exRfWr  <= idRfWr;
			exDmRd  <= idDmRd;
			exCp0Rd <= idCp0Rd;
			exRhlWr <= idRhlWr;
		end
	end

	// Fields below are don't care inside a bubble
	always_ff @(posedge clk) begin
		exRs       <= idRs;
		exRt       <= idRt;
		exDest     <= idDest;
		exRhlSelRd <= idRhlSelRd;
		exRhlSelWr <= idRhlSelWr;
	end

endmodule

`default_nettype wire

// ==== retireStages.sv ====
`timescale 1ns/1ns
`default_nettype none

module retireStages (
	input  wire                       clk,
	input  wire                       rst,
	input  wire  hazardPkg::regIdx_t  exDest,
	input  wire                       exRfWr,
	input  wire                       exDmRd,
	input  wire                       exCp0Rd,
	input  wire                       exRhlWr,
	input  wire  hazardPkg::hiloSel_t exRhlSelWr,
	output hazardPkg::regIdx_t        memDest,
	output logic                      memRfWr,
	output logic                      memDmRd,
	output logic                      memCp0Rd,
	output logic                      memRhlWr,
	output hazardPkg::hiloSel_t       memRhlSelWr,
	output hazardPkg::regIdx_t        wbDest,
	output logic                      wbRfWr,
	output logic                      wbRhlWr,
	output hazardPkg::hiloSel_t       wbRhlSelWr
);

	// EX/MEM rank
	always_ff @(posedge clk) begin
		if (rst) begin
			memRfWr  <= 1'b0;
			memDmRd  <= 1'b0;
			memCp0Rd <= 1'b0;
			memRhlWr <= 1'b0;
		end else begin
			memRfWr  <= exRfWr;
			memDmRd  <= exDmRd;	// Load still in flight
			memCp0Rd <= exCp0Rd;
			memRhlWr <= exRhlWr;
		end
	end

	// MEM/WB rank, read flags are done by now
	always_ff @(posedge clk) begin
		if (rst) begin
			wbRfWr  <= 1'b0;
			wbRhlWr <= 1'b0;
		end else begin
			wbRfWr  <= memRfWr;
			wbRhlWr <= memRhlWr;
		end
	end

	always_ff @(posedge clk) begin
		memDest     <= exDest;
		memRhlSelWr <= exRhlSelWr;
		wbDest      <= memDest;
		wbRhlSelWr  <= memRhlSelWr;
	end

endmodule

`default_nettype wire

// ==== bypassUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module bypassUnit (
	input  wire  hazardPkg::regIdx_t  exRs,
	input  wire  hazardPkg::regIdx_t  exRt,
	input  wire  hazardPkg::regIdx_t  idRs,
	input  wire  hazardPkg::regIdx_t  idRt,
	input  wire  hazardPkg::regIdx_t  memDest,
	input  wire  hazardPkg::regIdx_t  wbDest,
	input  wire                       memRfWr,
	input  wire                       wbRfWr,
	input  wire                       idBjOp,
	input  wire                       memRhlWr,
	input  wire                       wbRhlWr,
	input  wire                       exRhlSelRd,
	input  wire  hazardPkg::hiloSel_t memRhlSelWr,
	input  wire  hazardPkg::hiloSel_t wbRhlSelWr,
	output hazardPkg::fwdSel_t        fwdRs,
	output hazardPkg::fwdSel_t        fwdRt,
	output logic                      fwdBrRs,
	output logic                      fwdBrRt,
	output hazardPkg::hiloFwd_t       fwdHilo
);

	logic memHit;	// EX/MEM writes a real register
	logic wbHit;
	logic memBoth;	// Write of both HI and LO
	logic wbBoth;

	assign memHit  = memRfWr && (memDest != 5'd0);
	assign wbHit   = wbRfWr && (wbDest != 5'd0);
	assign memBoth = (memRhlSelWr == 2'b10);
	assign wbBoth  = (wbRhlSelWr == 2'b10);

	// ALU operands, nearest producer wins
	always_comb begin
		if (memHit && (memDest == exRs))
			fwdRs = hazardPkg::FwdExMem;
		else if (wbHit && (wbDest == exRs))
			fwdRs = hazardPkg::FwdMemWb;
		else
			fwdRs = hazardPkg::FwdNone;
	end

	always_comb begin
		if (memHit && (memDest == exRt))
			fwdRt = hazardPkg::FwdExMem;
		else if (wbHit && (wbDest == exRt))
			fwdRt = hazardPkg::FwdMemWb;
		else
			fwdRt = hazardPkg::FwdNone;
	end

	// Branch compare in decode only sees EX/MEM
	assign fwdBrRs = idBjOp && memHit && (memDest == idRs);
	assign fwdBrRt = idBjOp && memHit && (memDest == idRt);

	always_comb begin
		if (memRhlWr && memBoth && exRhlSelRd)
			fwdHilo = hazardPkg::HiloExHi;
		else if (memRhlWr && memBoth && !exRhlSelRd)
			fwdHilo = hazardPkg::HiloExLo;
		else if (memRhlWr && !memBoth && (memRhlSelWr[0] == exRhlSelRd))
			fwdHilo = hazardPkg::HiloExOne;
		else if (wbRhlWr && wbBoth && exRhlSelRd)
			fwdHilo = hazardPkg::HiloWbHi;
		else if (wbRhlWr && wbBoth && !exRhlSelRd)
			fwdHilo = hazardPkg::HiloWbLo;
		else if (wbRhlWr && !wbBoth && (wbRhlSelWr[0] == exRhlSelRd))
			fwdHilo = hazardPkg::HiloWbOne;
		else
			fwdHilo = hazardPkg::HiloNone;
	end

endmodule

`default_nettype wire

// ==== stallUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module stallUnit (
	input  wire  hazardPkg::regIdx_t exDest,
	input  wire  hazardPkg::regIdx_t memDest,
	input  wire  hazardPkg::regIdx_t idRs,
	input  wire  hazardPkg::regIdx_t idRt,
	input  wire                      exDmRd,
	input  wire                      exCp0Rd,
	input  wire                      memDmRd,
	input  wire                      memCp0Rd,
	input  wire                      exRfWr,
	input  wire                      idBjOp,
	output logic                     stall
);

	logic exMatch;	// ID/EX dest feeds a decode source
	logic memMatch;
	logic loadUse;
	logic brLoad;
	logic brAlu;

	// Register zero is not excluded here
	assign exMatch  = (exDest == idRs) || (exDest == idRt);
	assign memMatch = (memDest == idRs) || (memDest == idRt);

	// Load or CP0 read result not ready for EX
	assign loadUse = (exDmRd || exCp0Rd) && exMatch;

	// Branch needs the load result one cycle more
	assign brLoad = idBjOp && (memDmRd || memCp0Rd) && memMatch;

	// Branch compare cannot take the ALU result yet
	assign brAlu = idBjOp && exRfWr && exMatch;

	assign stall = loadUse || brLoad || brAlu;

endmodule

`default_nettype wire

// ==== hazardTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazardTop (
	input  wire                       clk,
	input  wire                       rst,
	input  wire  hazardPkg::regIdx_t  inRs,
	input  wire  hazardPkg::regIdx_t  inRt,
	input  wire  hazardPkg::regIdx_t  inDest,
	input  wire                       inRfWr,
	input  wire                       inDmRd,
	input  wire                       inCp0Rd,
	input  wire                       inBjOp,
	input  wire                       inRhlWr,
	input  wire  hazardPkg::hiloSel_t inRhlSelWr,
	input  wire                       inRhlSelRd,
	output logic                      fetchWr,
	output hazardPkg::fwdSel_t        fwdRs,
	output hazardPkg::fwdSel_t        fwdRt,
	output logic                      fwdBrRs,
	output logic                      fwdBrRt,
	output hazardPkg::hiloFwd_t       fwdHilo
);

	logic stall;

	hazardPkg::regIdx_t  idRs, idRt, idDest;
	logic                idRfWr, idDmRd, idCp0Rd, idBjOp, idRhlWr, idRhlSelRd;
	hazardPkg::hiloSel_t idRhlSelWr;

	hazardPkg::regIdx_t  exRs, exRt, exDest;
	logic                exRfWr, exDmRd, exCp0Rd, exRhlWr, exRhlSelRd;
	hazardPkg::hiloSel_t exRhlSelWr;

	hazardPkg::regIdx_t  memDest, wbDest;
	logic                memRfWr, memDmRd, memCp0Rd, memRhlWr, wbRfWr, wbRhlWr;
	hazardPkg::hiloSel_t memRhlSelWr, wbRhlSelWr;

	assign fetchWr = ~stall;	// Fetch and IF/ID advance together

	ifIdStage ifId_i (
		.clk(clk), .rst(rst), .stall(stall),
		.inRs(inRs), .inRt(inRt), .inDest(inDest), .inRfWr(inRfWr),
		.inDmRd(inDmRd), .inCp0Rd(inCp0Rd), .inBjOp(inBjOp), .inRhlWr(inRhlWr),
		.inRhlSelRd(inRhlSelRd), .inRhlSelWr(inRhlSelWr),
		.idRs(idRs), .idRt(idRt), .idDest(idDest), .idRfWr(idRfWr),
		.idDmRd(idDmRd), .idCp0Rd(idCp0Rd), .idBjOp(idBjOp), .idRhlWr(idRhlWr),
		.idRhlSelRd(idRhlSelRd), .idRhlSelWr(idRhlSelWr)
	);

	idExStage idEx_i (
		.clk(clk), .rst(rst), .stall(stall),
		.idRs(idRs), .idRt(idRt), .idDest(idDest), .idRfWr(idRfWr),
		.idDmRd(idDmRd), .idCp0Rd(idCp0Rd), .idRhlWr(idRhlWr),
		.idRhlSelRd(idRhlSelRd), .idRhlSelWr(idRhlSelWr),
		.exRs(exRs), .exRt(exRt), .exDest(exDest), .exRfWr(exRfWr),
		.exDmRd(exDmRd), .exCp0Rd(exCp0Rd), .exRhlWr(exRhlWr),
		.exRhlSelRd(exRhlSelRd), .exRhlSelWr(exRhlSelWr)
	);

	retireStages retire_i (
		.clk(clk), .rst(rst),
		.exDest(exDest), .exRfWr(exRfWr), .exDmRd(exDmRd), .exCp0Rd(exCp0Rd),
		.exRhlWr(exRhlWr), .exRhlSelWr(exRhlSelWr),
		.memDest(memDest), .memRfWr(memRfWr), .memDmRd(memDmRd), .memCp0Rd(memCp0Rd),
		.memRhlWr(memRhlWr), .memRhlSelWr(memRhlSelWr),
		.wbDest(wbDest), .wbRfWr(wbRfWr), .wbRhlWr(wbRhlWr), .wbRhlSelWr(wbRhlSelWr)
	);

	bypassUnit bypass_i (
		.exRs(exRs), .exRt(exRt), .idRs(idRs), .idRt(idRt),
		.memDest(memDest), .wbDest(wbDest), .memRfWr(memRfWr), .wbRfWr(wbRfWr),
		.idBjOp(idBjOp), .memRhlWr(memRhlWr), .wbRhlWr(wbRhlWr),
		.exRhlSelRd(exRhlSelRd), .memRhlSelWr(memRhlSelWr), .wbRhlSelWr(wbRhlSelWr),
		.fwdRs(fwdRs), .fwdRt(fwdRt), .fwdBrRs(fwdBrRs), .fwdBrRt(fwdBrRt),
		.fwdHilo(fwdHilo)
	);

	stallUnit stall_i (
		.exDest(exDest), .memDest(memDest), .idRs(idRs), .idRt(idRt),
		.exDmRd(exDmRd), .exCp0Rd(exCp0Rd), .memDmRd(memDmRd), .memCp0Rd(memCp0Rd),
		.exRfWr(exRfWr), .idBjOp(idBjOp), .stall(stall)
	);

endmodule

`default_nettype wire

// ==== hazardTop_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazardTop_sva (
	input wire                       clk,
	input wire                       rst,
	input wire                       fetchWr,
	input wire  hazardPkg::fwdSel_t  fwdRs,
	input wire  hazardPkg::fwdSel_t  fwdRt,
	input wire  hazardPkg::hiloFwd_t fwdHilo
);

	int failCount = 0;	// Failed assertion attempts

	fetchAfterReset: assert property (@(posedge clk) $fell(rst) |-> fetchWr)
		else begin
			$error("fetchWr low in the first cycle after reset");	// Ranks are clear
			failCount++;
		end

	operandCode: assert property (@(posedge clk) disable iff (rst)
		(fwdRs != 2'd3) && (fwdRt != 2'd3))
		else begin
			$error("Operand forwarding select uses unused code 3");
			failCount++;
		end

	hiloCode: assert property (@(posedge clk) disable iff (rst) fwdHilo != 3'd7)
		else begin
			$error("HI/LO forwarding select uses unused code 7");
			failCount++;
		end

	// Branch behind a load is the longest case
	stallLength: assert property (@(posedge clk) disable iff (rst)
		!fetchWr ##1 !fetchWr |=> fetchWr)
		else begin
			$error("Stall lasted more than two cycles");
			failCount++;
		end

endmodule

bind hazardTop hazardTop_sva sva_i (
	.clk(clk), .rst(rst), .fetchWr(fetchWr),
	.fwdRs(fwdRs), .fwdRt(fwdRt), .fwdHilo(fwdHilo)
);

`default_nettype wire

// ==== hazardTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazardTb;

	localparam int NumCycles = 3000;
	localparam int TimeoutNs = (8 + NumCycles + 20) * 20;	// Reset, test cycles and margin

	typedef struct packed {
		hazardPkg::regIdx_t rs, rt, dest;
		logic rfWr, dmRd, cp0Rd, bjOp, rhlWr, rhlSelRd;
		hazardPkg::hiloSel_t rhlSelWr;
	} desc_t;

	logic clk;
	logic rst;
	desc_t fetchDesc;	// Descriptor on the DUT inputs
	desc_t mId, mEx, mMem, mWb;	// Model ranks
	logic fetchWr, fwdBrRs, fwdBrRt;
	hazardPkg::fwdSel_t fwdRs, fwdRt;
	hazardPkg::hiloFwd_t fwdHilo;
	integer seed;
	int cycle;
	int fwdErrs, hiloErrs, bitErrs, covErrs, assertErrs;
	int stallCount;
	logic stallNow;
	logic [6:0] hiloSeen;

	hazardTop dut_i (
		.clk(clk), .rst(rst),
		.inRs(fetchDesc.rs), .inRt(fetchDesc.rt), .inDest(fetchDesc.dest),
		.inRfWr(fetchDesc.rfWr), .inDmRd(fetchDesc.dmRd), .inCp0Rd(fetchDesc.cp0Rd),
		.inBjOp(fetchDesc.bjOp), .inRhlWr(fetchDesc.rhlWr),
		.inRhlSelWr(fetchDesc.rhlSelWr), .inRhlSelRd(fetchDesc.rhlSelRd),
		.fetchWr(fetchWr), .fwdRs(fwdRs), .fwdRt(fwdRt),
		.fwdBrRs(fwdBrRs), .fwdBrRt(fwdBrRt), .fwdHilo(fwdHilo)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#(TimeoutNs);
		$display("Watchdog expired after %0d ns, the run did not complete", TimeoutNs);
		$display("*** TEST FAILED ***");
		$finish;
	end

	function automatic logic readsId(hazardPkg::regIdx_t r);	// Decode source match
		return (r == mId.rs) || (r == mId.rt);
	endfunction

	function automatic logic expStall();
		if ((mEx.dmRd || mEx.cp0Rd) && readsId(mEx.dest))
			return 1'b1;	// Load-use
		if (mId.bjOp && (mMem.dmRd || mMem.cp0Rd) && readsId(mMem.dest))
			return 1'b1;	// Branch behind load
		return mId.bjOp && mEx.rfWr && readsId(mEx.dest);
	endfunction

	function automatic logic writes(desc_t d, hazardPkg::regIdx_t r);	// Nonzero register write
		return d.rfWr && (d.dest != 5'd0) && (d.dest == r);
	endfunction

	function automatic hazardPkg::fwdSel_t expOperand(hazardPkg::regIdx_t r);
		if (writes(mMem, r))
			return hazardPkg::FwdExMem;
		return writes(mWb, r) ? hazardPkg::FwdMemWb : hazardPkg::FwdNone;
	endfunction

	function automatic hazardPkg::hiloFwd_t rankHilo(desc_t d, hazardPkg::hiloFwd_t hi,
			hazardPkg::hiloFwd_t lo, hazardPkg::hiloFwd_t one);
		if (!d.rhlWr)
			return hazardPkg::HiloNone;
		if (d.rhlSelWr == 2'b10)
			return mEx.rhlSelRd ? hi : lo;	// Both halves written
		return (d.rhlSelWr[0] == mEx.rhlSelRd) ? one : hazardPkg::HiloNone;
	endfunction

	function automatic hazardPkg::hiloFwd_t expHilo();
		hazardPkg::hiloFwd_t nearCode;
		nearCode = rankHilo(mMem, hazardPkg::HiloExHi, hazardPkg::HiloExLo, hazardPkg::HiloExOne);
		if (nearCode != hazardPkg::HiloNone)
			return nearCode;
		return rankHilo(mWb, hazardPkg::HiloWbHi, hazardPkg::HiloWbLo, hazardPkg::HiloWbOne);
	endfunction

	task automatic checkFwd(string name, hazardPkg::fwdSel_t expVal, hazardPkg::fwdSel_t actVal);
		if (actVal !== expVal) begin
			fwdErrs++;
			$display("[FAIL] %s cycle %0d: expected %0d, actual %0d", name, cycle, expVal, actVal);
		end
	endtask

	task automatic checkHilo(string name, hazardPkg::hiloFwd_t expVal,
			hazardPkg::hiloFwd_t actVal);
		if (actVal !== expVal) begin
			hiloErrs++;
			$display("[FAIL] %s cycle %0d: expected %0d, actual %0d", name, cycle, expVal, actVal);
		end
	endtask

	task automatic checkBit(string name, logic expVal, logic actVal);
		if (actVal !== expVal) begin
			bitErrs++;
			$display("[FAIL] %s cycle %0d: expected %b, actual %b", name, cycle, expVal, actVal);
		end
	endtask

	task automatic drawDesc();
		logic [31:0] r;
		r = $random(seed);
		fetchDesc = '0;
		fetchDesc.rs = {3'b0, r[1:0]};	// Small range keeps hazards frequent
		fetchDesc.rt = {3'b0, r[3:2]};
		fetchDesc.dmRd = (r[8:6] == 3'd1);
		fetchDesc.cp0Rd = (r[8:6] == 3'd2);
		fetchDesc.bjOp = (r[8:6] == 3'd3) || (r[8:6] == 3'd4);
		fetchDesc.rfWr = !fetchDesc.bjOp && (fetchDesc.dmRd || fetchDesc.cp0Rd || r[9]);
		fetchDesc.dest = (fetchDesc.dmRd || fetchDesc.cp0Rd) ? fetchDesc.rt : {3'b0, r[5:4]};
		fetchDesc.rhlWr = r[10];
		fetchDesc.rhlSelWr = r[12:11];
		fetchDesc.rhlSelRd = r[13];
	endtask

	task automatic checkOutputs();
		hazardPkg::hiloFwd_t expH;
		expH = expHilo();
		checkBit("fetchWr", !expStall(), fetchWr);
		checkFwd("fwdRs", expOperand(mEx.rs), fwdRs);
		checkFwd("fwdRt", expOperand(mEx.rt), fwdRt);
		checkBit("fwdBrRs", mId.bjOp && writes(mMem, mId.rs), fwdBrRs);
		checkBit("fwdBrRt", mId.bjOp && writes(mMem, mId.rt), fwdBrRt);
		checkHilo("fwdHilo", expH, fwdHilo);
		hiloSeen[expH] = 1'b1;
	endtask

	initial begin
		seed = 32'ha5a815a9;
		fetchDesc = '0;
		mId = '0;
		mEx = '0;
		mMem = '0;
		mWb = '0;
		fwdErrs = 0;
		hiloErrs = 0;
		bitErrs = 0;
		covErrs = 0;
		assertErrs = 0;
		stallCount = 0;
		hiloSeen = '0;
		cycle = 0;
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#2 rst = 1'b0;
		drawDesc();
		for (cycle = 0; cycle < NumCycles; cycle++) begin
			@(negedge clk);
			checkOutputs();	// Cycle 0 covers the state right after reset
			@(posedge clk);
			stallNow = expStall();
			stallCount += stallNow;
			mWb = mMem;
			mMem = mEx;
			mEx = mId;
			if (stallNow) begin	// Bubble keeps the fields, clears the enables
				mEx.rfWr = 1'b0;
				mEx.dmRd = 1'b0;
				mEx.cp0Rd = 1'b0;
				mEx.rhlWr = 1'b0;
			end else begin
				mId = fetchDesc;
			end
			#2;
			if (!stallNow)
				drawDesc();
		end
		if (hiloSeen[6:1] != 6'h3f) begin
			covErrs++;
			$display("Not every HI/LO forwarding code was produced, seen mask %b", hiloSeen);
		end
		if (stallCount == 0) begin
			covErrs++;
			$display("The random stimulus never produced a stall");
		end
		assertErrs = dut_i.sva_i.failCount;
		$display("Errors: fwd %0d, hilo %0d, bit %0d, sva %0d, coverage %0d, stalls seen %0d",
			fwdErrs, hiloErrs, bitErrs, assertErrs, covErrs, stallCount);
		if (fwdErrs + hiloErrs + bitErrs + assertErrs + covErrs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
hazardPkg.sv
ifIdStage.sv
idExStage.sv
retireStages.sv
bypassUnit.sv
stallUnit.sv
hazardTop.sv
hazardTop_sva.sv
hazardTb.sv
